// File: list.f
common/router_pkg.sv
fifo/router_fifo.sv
hdl/route_compute.sv
hdl/input_port.sv
arbiter/output_arbiter.sv
hdl/noc_router.sv
sim/router_chk.sv
sim/tb_noc_router.sv

// File: Makefile
TOOL     = verilator
TOP      = tb_noc_router
FILELIST = list.f
FLAGS    = --binary --timing --assert -Wno-fatal
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tb_noc_router.sv
`timescale 1ns/1ps

module tb_noc_router;
  import router_pkg::*;

  localparam int tile_x = 1;
  localparam int tile_y = 1;
  localparam int max_cycles = 5000;

  logic                 clk;
  logic                 rst;
  flit_t                rx_data [num_ports];
  logic [num_ports-1:0] rx_rts;
  logic [num_ports-1:0] rx_dcts;
  flit_t                tx_data [num_ports];
  logic [num_ports-1:0] tx_rts;
  logic [num_ports-1:0] tx_dcts;

  flit_t exp_q [num_ports][$];
  flit_t pkt_buf [num_ports][$];
  int    sent_count [num_ports];
  int    mismatch_count = 0;
  int    fail_count = 0;
  int    cycles = 0;

  noc_router #(
    .cur_x (tile_x),
    .cur_y (tile_y)
  ) i_noc_router (
    .clk     (clk),
    .rst     (rst),
    .rx_data (rx_data),
    .rx_rts  (rx_rts),
    .rx_dcts (rx_dcts),
    .tx_data (tx_data),
    .tx_rts  (tx_rts),
    .tx_dcts (tx_dcts)
  );

  bind output_arbiter router_chk i_router_chk (
    .clk     (clk),
    .rst     (rst),
    .pop     (pop),
    .tx_data (tx_data),
    .tx_rts  (tx_rts),
    .tx_dcts (tx_dcts)
  );

  initial begin : clock
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic check_value(string name, flit_t exp, flit_t act);
    assert (act == exp) else begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("error: %s", what);
      fail_count++;
    end
  endtask

  task automatic step(int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // larger x is east, larger y is south
  function automatic int xy_port(int dx, int dy);
    if (dx > tile_x) return port_e;
    if (dx < tile_x) return port_w;
    if (dy > tile_y) return port_s;
    if (dy < tile_y) return port_n;
    return port_l;
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int o = 0; o < num_ports; o++) begin
      total += exp_q[o].size();
    end
    return total;
  endfunction

  // one-flit packets are a lone tail that carries the destination
  task automatic build_packet(int src, int dx, int dy, int len);
    flit_kind_t kind;
    flit_t      f;
    pkt_buf[src].delete();
    for (int i = 0; i < len; i++) begin
      if (len == 1 || i == len - 1) kind = kind_tail;
      else if (i == 0) kind = kind_header;
      else kind = kind_body;
      if (i == 0) f = {kind, coord_w'(dy), coord_w'(dx), 26'($urandom())};
      else f = {kind, 4'($urandom()), 26'($urandom())};
      pkt_buf[src].push_back(f);
    end
  endtask

  task automatic expect_packet(int src, int out);
    for (int i = 0; i < pkt_buf[src].size(); i++) begin
      exp_q[out].push_back(pkt_buf[src][i]);
    end
  endtask

  task automatic send_flit(int p, flit_t f);
    logic accepted;
    rx_data[p] = f;
    rx_rts[p] = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = rx_dcts[p];
      step(1);
    end
    rx_rts[p] = 1'b0;
    sent_count[p]++;
    step(1);
  endtask

  task automatic send_packet(int src);
    for (int i = 0; i < pkt_buf[src].size(); i++) begin
      send_flit(src, pkt_buf[src][i]);
    end
  endtask

  task automatic wait_drain();
    while (pending() != 0) begin
      step(1);
    end
    step(4);
  endtask

  task automatic record_flit(int o, flit_t f);
    flit_t exp;
    check_true(exp_q[o].size() != 0, $sformatf("unexpected flit %h on output %0d", f, o));
    if (exp_q[o].size() != 0) begin
      exp = exp_q[o].pop_front();
      check_value($sformatf("tx_data[%0d]", o), exp, f);
    end
  endtask

  initial begin : monitor
    forever begin
      @(negedge clk);
      for (int o = 0; o < num_ports; o++) begin
        if (!rst && tx_rts[o] && tx_dcts[o]) begin
          record_flit(o, tx_data[o]);
        end
      end
    end
  end

  task automatic test_reset();
    repeat (3) begin
      @(negedge clk);
      check_value("tx_rts", '0, flit_t'(tx_rts));
      check_value("rx_dcts", '0, flit_t'(rx_dcts));
      step(1);
    end
    tx_dcts = '1;
  endtask

  task automatic test_xy_routing();
    int dst_x [5] = '{0, 2, 1, 1, 1};
    int dst_y [5] = '{1, 1, 0, 2, 1};
    int exp_out [5] = '{port_w, port_e, port_n, port_s, port_l};
    for (int d = 0; d < 5; d++) begin
      for (int len = 1; len <= 3; len += 2) begin
        build_packet(port_l, dst_x[d], dst_y[d], len);
        expect_packet(port_l, exp_out[d]);
        send_packet(port_l);
        wait_drain();
      end
    end
  endtask

  // idle arbiter order is L N E W S, so east wins
  task automatic test_contention();
    int out;
    out = xy_port(0, 1);
    build_packet(port_e, 0, 1, 4);
    build_packet(port_s, 0, 1, 4);
    expect_packet(port_e, out);
    expect_packet(port_s, out);
    fork
      send_packet(port_e);
      send_packet(port_s);
    join
    wait_drain();
  endtask

  task automatic test_rotation();
    int out;
    out = xy_port(2, 1);
    tx_dcts[out] = 1'b0;
    build_packet(port_n, 2, 1, 3);
    build_packet(port_w, 2, 1, 3);
    build_packet(port_l, 2, 1, 3);
    // local from idle, then the next requesters after it: north, west
    expect_packet(port_l, out);
    expect_packet(port_n, out);
    expect_packet(port_w, out);
    fork
      send_packet(port_n);
      send_packet(port_w);
      send_packet(port_l);
    join
    @(negedge clk);
    check_value("tx_data[e]", pkt_buf[port_l][0], tx_data[out]);
    step(1);
    tx_dcts[out] = 1'b1;
    wait_drain();
  endtask

  task automatic test_backpressure();
    int out;
    int base;
    out = xy_port(1, 2);
    tx_dcts[out] = 1'b0;
    build_packet(port_n, 1, 2, 6);
    expect_packet(port_n, out);
    base = sent_count[port_n];
    fork
      send_packet(port_n);
      begin
        // header sits in the tx register, the fifo holds the rest
        while (sent_count[port_n] < base + fifo_depth + 1) begin
          step(1);
        end
        repeat (20) begin
          @(negedge clk);
          check_value("rx_dcts[n]", '0, flit_t'(rx_dcts[port_n]));
          check_value("tx_rts[s]", flit_t'(1), flit_t'(tx_rts[out]));
          check_value("tx_data[s]", pkt_buf[port_n][0], tx_data[out]);
          step(1);
        end
        check_value("accepted flits", flit_t'(base + fifo_depth + 1),
                    flit_t'(sent_count[port_n]));
        tx_dcts[out] = 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic print_summary();
    $display("errors: %0d value mismatches, %0d other failures",
             mismatch_count, fail_count);
  endtask

  initial begin : watchdog
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", max_cycles);
    fail_count++;
    print_summary();
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : main
    void'($urandom(32'hdbcc38f3));
    rst = 1'b1;
    rx_rts = '0;
    tx_dcts = '0;
    for (int p = 0; p < num_ports; p++) begin
      rx_data[p] = '0;
      sent_count[p] = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_xy_routing();
    test_contention();
    test_rotation();
    test_backpressure();
    print_summary();
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/router_chk.sv
`timescale 1ns/1ps

module router_chk (
  input logic                  clk,
  input logic                  rst,
  input router_pkg::port_vec_t pop,
  input router_pkg::flit_t     tx_data,
  input logic                  tx_rts,
  input logic                  tx_dcts
);

  // a waiting flit keeps rts and data until dcts
  a_hold_while_blocked: assert property (
    @(posedge clk) disable iff (rst)
    tx_rts && !tx_dcts |=> tx_rts && $stable(tx_data)
  ) else $error("tx_rts or tx_data changed while the link was blocked");

  a_pop_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(pop)
  ) else $error("pop vector has more than one bit set");

  // rts gap after every transfer
  a_rts_drops: assert property (
    @(posedge clk) disable iff (rst)
    tx_rts && tx_dcts |=> !tx_rts
  ) else $error("tx_rts stayed high after a transfer");

endmodule

// File: hdl/noc_router.sv
`timescale 1ns/1ps

module noc_router #(
  parameter int cur_x = 0,
  parameter int cur_y = 0
) (
  input  logic                            clk,
  input  logic                            rst,
  input  router_pkg::flit_t               rx_data [router_pkg::num_ports],
  input  logic [router_pkg::num_ports-1:0] rx_rts,
  output logic [router_pkg::num_ports-1:0] rx_dcts,
  output router_pkg::flit_t               tx_data [router_pkg::num_ports],
  output logic [router_pkg::num_ports-1:0] tx_rts,
  input  logic [router_pkg::num_ports-1:0] tx_dcts
);
  import router_pkg::*;

  flit_t     head_flit [num_ports];
  port_vec_t in_req    [num_ports];
  port_vec_t in_valid;
  port_vec_t in_pop;
  port_vec_t arb_req   [num_ports];
  port_vec_t arb_pop   [num_ports];

  for (genvar i = 0; i < num_ports; i++) begin : g_in
    input_port #(
      .cur_x (cur_x),
      .cur_y (cur_y)
    ) i_input_port (
      .clk       (clk),
      .rst       (rst),
      .rx_data   (rx_data[i]),
      .rx_rts    (rx_rts[i]),
      .rx_dcts   (rx_dcts[i]),
      .pop       (in_pop[i]),
      .req       (in_req[i]),
      .valid     (in_valid[i]),
      .head_flit (head_flit[i])
    );
  end

  // arbiter j sees bit j of every input's route
  for (genvar j = 0; j < num_ports; j++) begin : g_col
    for (genvar i = 0; i < num_ports; i++) begin : g_bit
      assign arb_req[j][i] = in_req[i][j];
    end
  end

  always_comb begin : pop_merge
    in_pop = '0;
    for (int j = 0; j < num_ports; j++) begin
      in_pop = in_pop | arb_pop[j];
    end
  end

  for (genvar j = 0; j < num_ports; j++) begin : g_out
    output_arbiter i_output_arbiter (
      .clk      (clk),
      .rst      (rst),
      .req      (arb_req[j]),
      .valid    (in_valid),
      .in_flits (head_flit),
      .pop      (arb_pop[j]),
      .tx_data  (tx_data[j]),
      .tx_rts   (tx_rts[j]),
      .tx_dcts  (tx_dcts[j])
    );
  end

endmodule

// File: arbiter/output_arbiter.sv
`timescale 1ns/1ps

module output_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  router_pkg::port_vec_t req,
  input  router_pkg::port_vec_t valid,
  input  router_pkg::flit_t     in_flits [router_pkg::num_ports],
  output router_pkg::port_vec_t pop,
  output router_pkg::flit_t     tx_data,
  output logic                  tx_rts,
  input  logic                  tx_dcts
);
  import router_pkg::*;

  // bit 0 is idle, bit p+1 serves input p
  logic [num_ports:0]    state;
  logic [num_ports:0]    state_next;
  logic                  idle;
  port_vec_t             sel;
  port_vec_t             grant_next;
  logic [port_idx_w-1:0] cur_idx;
  logic [port_idx_w-1:0] start_idx;
  flit_t                 sel_flit;
  logic                  stall;
  logic                  tx_free;
  logic                  load;

  assign idle = state[0];
  assign sel = state[num_ports:1];

  always_comb begin : encode
    cur_idx = '0;
    for (int p = 0; p < num_ports; p++) begin
      if (sel[p]) begin
        cur_idx = port_idx_w'(p);
      end
    end
  end

  // from idle start at local, giving L N E W S
  assign start_idx = idle ? port_idx_w'(port_l) : cur_idx;

  // lowest offset from start wins, so a served input keeps its grant
  always_comb begin : rotate
    int idx;
    grant_next = '0;
    for (int off = num_ports - 1; off >= 0; off--) begin
      idx = (int'(start_idx) + off) % num_ports;
      if (req[idx]) begin
        grant_next = '0;
        grant_next[idx] = 1'b1;
      end
    end
  end

  assign state_next = {grant_next, grant_next == '0};

  // frozen while a flit waits for dcts
  assign stall = tx_rts && !tx_dcts;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= {port_vec_t'('0), 1'b1};
    end else if (!stall) begin
      state <= state_next;
    end
  end

  // crossbar column
  always_comb begin : xbar
    sel_flit = '0;
    for (int p = 0; p < num_ports; p++) begin
      if (sel[p]) begin
        sel_flit = sel_flit | in_flits[p];
      end
    end
  end

  assign tx_free = !tx_rts;
  assign load = tx_free && ((sel & req & valid) != '0);
  assign pop = load ? sel : '0;

  always_ff @(posedge clk) begin
    if (load) begin
      tx_data <= sel_flit;
    end
  end

  // rts drops for a cycle after each transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_rts <= 1'b0;
    end else if (load) begin
      tx_rts <= 1'b1;
    end else if (tx_rts && tx_dcts) begin
      tx_rts <= 1'b0;
    end
  end

endmodule

// File: hdl/input_port.sv
`timescale 1ns/1ps

module input_port #(
  parameter int cur_x = 0,
  parameter int cur_y = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  router_pkg::flit_t     rx_data,
  input  logic                  rx_rts,
  output logic                  rx_dcts,
  input  logic                  pop,
  output router_pkg::port_vec_t req,
  output logic                  valid,
  output router_pkg::flit_t     head_flit
);
  import router_pkg::*;

  port_vec_t  route;
  port_vec_t  lock_route;
  logic       locked;
  flit_kind_t head_kind;
  logic       opens_packet;

  router_fifo i_router_fifo (
    .clk       (clk),
    .rst       (rst),
    .rx_data   (rx_data),
    .rx_rts    (rx_rts),
    .rx_dcts   (rx_dcts),
    .pop       (pop),
    .head_flit (head_flit),
    .valid     (valid)
  );

  route_compute #(
    .cur_x (cur_x),
    .cur_y (cur_y)
  ) i_route_compute (
    .flit  (head_flit),
    .route (route)
  );

  assign head_kind = flit_kind(head_flit);
  assign opens_packet = (head_kind == kind_header) || (head_kind == kind_tail);

  // route stays locked until the tail leaves the fifo
  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      lock_route <= '0;
    end else if (!locked) begin
      if (valid && opens_packet) begin
        locked <= 1'b1;
        lock_route <= route;
      end
    end else if (pop && valid && head_kind == kind_tail) begin
      locked <= 1'b0;
      lock_route <= '0;
    end
  end

  assign req = lock_route;

endmodule

// File: hdl/route_compute.sv
`timescale 1ns/1ps

module route_compute #(
  parameter int cur_x = 0,
  parameter int cur_y = 0
) (
  input  router_pkg::flit_t     flit,
  output router_pkg::port_vec_t route
);
  import router_pkg::*;

  logic [coord_w-1:0] dst_x;
  logic [coord_w-1:0] dst_y;
  logic [coord_w-1:0] here_x;
  logic [coord_w-1:0] here_y;

  assign dst_x = flit_dst_x(flit);
  assign dst_y = flit_dst_y(flit);
  assign here_x = coord_w'(cur_x);
  assign here_y = coord_w'(cur_y);

  // x first, then y; larger x is east, larger y is south
  always_comb begin
    route = '0;
    if (dst_x > here_x) begin
      route[port_e] = 1'b1;
    end else if (dst_x < here_x) begin
      route[port_w] = 1'b1;
    end else if (dst_y > here_y) begin
      route[port_s] = 1'b1;
    end else if (dst_y < here_y) begin
      route[port_n] = 1'b1;
    end else begin
      route[port_l] = 1'b1;
    end
  end

endmodule

// File: fifo/router_fifo.sv
`timescale 1ns/1ps

module router_fifo (
  input  logic              clk,
  input  logic              rst,
  input  router_pkg::flit_t rx_data,
  input  logic              rx_rts,
  output logic              rx_dcts,
  input  logic              pop,
  output router_pkg::flit_t head_flit,
  output logic              valid
);
  import router_pkg::*;

  flit_t                 mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  full;
  logic                  push;
  logic                  do_pop;

  assign full = (count == (fifo_ptr_w + 1)'(fifo_depth));

  // clear to send only while the sender is asking and there is room
  assign rx_dcts = rx_rts && !full;
  assign push = rx_dcts;

  assign valid = (count != '0);
  assign do_pop = pop && valid;
  assign head_flit = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_data;
    end
  end

  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, do_pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// File: common/router_pkg.sv
package router_pkg;

  localparam int flit_w = 32;
  localparam int coord_w = 2;

  localparam int num_ports = 5;
  localparam int port_idx_w = $clog2(num_ports);

  // round-robin order follows the index
  localparam int port_n = 0;
  localparam int port_e = 1;
  localparam int port_w = 2;
  localparam int port_s = 3;
  localparam int port_l = 4;

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // [31:30] kind, [29:28] dst y, [27:26] dst x, [25:0] payload
  typedef logic [flit_w-1:0] flit_t;

  // a tail arriving with no open route is a one-flit packet and carries the destination
  typedef enum logic [1:0] {
    kind_header = 2'd0,
    kind_body   = 2'd1,
    kind_tail   = 2'd2
  } flit_kind_t;

  typedef logic [num_ports-1:0] port_vec_t;

  function automatic flit_kind_t flit_kind(input flit_t f);
    return flit_kind_t'(f[31:30]);
  endfunction

  function automatic logic [coord_w-1:0] flit_dst_y(input flit_t f);
    return f[29:28];
  endfunction

  function automatic logic [coord_w-1:0] flit_dst_x(input flit_t f);
    return f[27:26];
  endfunction

endpackage
